// ==== Bender.yml ====
package:
  name: riscv_core_ex

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - riscv_isa_pkg.sv
      - riscv_md_pkg.sv
      - riscv_core_alu.sv
      - riscv_core_mul_div.sv
      - riscv_core_ex_writeback.sv
      - riscv_core_ex_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_riscv_core_ex.sv

// ==== riscv_core_alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_ex_params.svh"

module riscv_core_alu (
	input  logic [`XLEN-1:0]       i_src_a,
	input  logic [`XLEN-1:0]       i_src_b,
	input  riscv_isa_pkg::alu_op_e i_alu_op,
	input  logic                   i_isword,
	output logic [`XLEN-1:0]       o_result
);
	import riscv_isa_pkg::*;

	localparam int XW = `XLEN;
	localparam int WW = `WORD_W;
	localparam int SH_W = $clog2(XW);
	localparam int WSH_W = $clog2(WW);

	logic [XW-1:0] op_a;
	logic [XW-1:0] op_b;
	logic [XW-1:0] raw;
	logic [SH_W-1:0] shamt;

	// word mode runs on extended low halves so one datapath serves both.
	always_comb begin
		op_a = i_src_a;
		op_b = i_src_b;
		shamt = i_src_b[SH_W-1:0];
		if (i_isword) begin
			if (i_alu_op == ALU_SRL) begin
				op_a = {{(XW-WW){1'b0}}, i_src_a[WW-1:0]};
			end else begin
				op_a = {{(XW-WW){i_src_a[WW-1]}}, i_src_a[WW-1:0]};
			end
			op_b = {{(XW-WW){i_src_b[WW-1]}}, i_src_b[WW-1:0]};
			shamt = SH_W'(i_src_b[WSH_W-1:0]);
		end
	end

	always_comb begin
		case (i_alu_op)
			ALU_ADD:  raw = op_a + op_b;
			ALU_SUB:  raw = op_a - op_b;
			ALU_SLL:  raw = op_a << shamt;
			ALU_SLT:  raw = {{(XW-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: raw = {{(XW-1){1'b0}}, op_a < op_b};
			ALU_XOR:  raw = op_a ^ op_b;
			ALU_SRL:  raw = op_a >> shamt;
			ALU_SRA:  raw = $signed(op_a) >>> shamt;
			ALU_OR:   raw = op_a | op_b;
			ALU_AND:  raw = op_a & op_b;
			default:  raw = '0;
		endcase
	end

	// w results are sign-extended from bit 31.
	always_comb begin
		if (i_isword) begin
			o_result = {{(XW-WW){raw[WW-1]}}, raw[WW-1:0]};
		end else begin
			o_result = raw;
		end
	end

endmodule

`default_nettype wire

// ==== riscv_core_ex.f ====
+incdir+.
riscv_isa_pkg.sv
riscv_md_pkg.sv
riscv_core_alu.sv
riscv_core_mul_div.sv
riscv_core_ex_writeback.sv
riscv_core_ex_top.sv
tb_riscv_core_ex.sv

// ==== riscv_core_ex_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_ex_params.svh"

module riscv_core_ex_top (
	input  logic                   i_riscv_core_clk,
	input  logic                   i_rst_n,
	input  logic                   i_valid,
	input  logic                   i_md_sel,
	input  riscv_isa_pkg::alu_op_e i_alu_op,
	input  riscv_isa_pkg::md_op_e  i_md_op,
	input  logic                   i_isword,
	input  logic [`XLEN-1:0]       i_src_a,
	input  logic [`XLEN-1:0]       i_src_b,
	input  logic [`REG_ADDR_W-1:0] i_rd,
	output logic                   o_valid,
	output logic [`XLEN-1:0]       o_result,
	output logic [`REG_ADDR_W-1:0] o_rd,
	output logic                   o_busy
);
	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] md_result;
	logic md_start;
	logic md_done;

	riscv_core_alu u_riscv_core_alu (
		.i_src_a(i_src_a),
		.i_src_b(i_src_b),
		.i_alu_op(i_alu_op),
		.i_isword(i_isword),
		.o_result(alu_result)
	);

	riscv_core_mul_div #(.XLEN(`XLEN)) u_riscv_core_mul_div (
		.i_clk(i_riscv_core_clk),
		.i_rst_n(i_rst_n),
		.i_start(md_start),
		.i_md_op(i_md_op),
		.i_isword(i_isword),
		.i_src_a(i_src_a),
		.i_src_b(i_src_b),
		.o_result(md_result),
		.o_busy(o_busy),
		.o_done(md_done)
	);

	riscv_core_ex_writeback u_riscv_core_ex_writeback (
		.i_clk(i_riscv_core_clk),
		.i_rst_n(i_rst_n),
		.i_valid(i_valid),
		.i_md_sel(i_md_sel),
		.i_rd(i_rd),
		.i_alu_result(alu_result),
		.i_md_result(md_result),
		.i_md_busy(o_busy),
		.i_md_done(md_done),
		.o_md_start(md_start),
		.o_valid(o_valid),
		.o_result(o_result),
		.o_rd(o_rd)
	);

endmodule

`default_nettype wire

// ==== riscv_core_ex_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_ex_params.svh"

module riscv_core_ex_writeback (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_valid,
	input  logic                   i_md_sel,
	input  logic [`REG_ADDR_W-1:0] i_rd,
	input  logic [`XLEN-1:0]       i_alu_result,
	input  logic [`XLEN-1:0]       i_md_result,
	input  logic                   i_md_busy,
	input  logic                   i_md_done,
	output logic                   o_md_start,
	output logic                   o_valid,
	output logic [`XLEN-1:0]       o_result,
	output logic [`REG_ADDR_W-1:0] o_rd
);
	logic md_idle;
	logic accept;
	logic alu_fire;
	logic [`REG_ADDR_W-1:0] md_rd_q;

	// nothing is taken while the unit works or drains its result.
	assign md_idle = !i_md_busy && !i_md_done;
	assign accept = i_valid && md_idle;
	assign alu_fire = accept && !i_md_sel;
	assign o_md_start = accept && i_md_sel;

	// tag of the operation in the mul/div unit.
	always_ff @(posedge i_clk) begin
		if (o_md_start) begin
			md_rd_q <= i_rd;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= alu_fire || i_md_done;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_md_done) begin
			o_result <= i_md_result;
			o_rd <= md_rd_q;
		end else if (alu_fire) begin
			o_result <= i_alu_result;
			o_rd <= i_rd;
		end
	end

	a_no_valid_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_md_busy |-> !i_valid);

	// alu and mul/div never finish together.
	a_one_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_valid && !i_md_sel && i_md_done));

	a_busy_after_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_md_start |=> i_md_busy);

endmodule

`default_nettype wire

// ==== riscv_core_mul_div.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_ex_params.svh"

module riscv_core_mul_div #(
	parameter int XLEN = `XLEN
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_start,
	input  riscv_isa_pkg::md_op_e i_md_op,
	input  logic                  i_isword,
	input  logic [XLEN-1:0]       i_src_a,
	input  logic [XLEN-1:0]       i_src_b,
	output logic [XLEN-1:0]       o_result,
	output logic                  o_busy,
	output logic                  o_done
);
	import riscv_isa_pkg::*;
	import riscv_md_pkg::*;

	localparam int WW = `WORD_W;
	localparam int CNT_W = $clog2(XLEN);

	md_state_e state;
	logic [CNT_W-1:0] cnt;
	md_op_e op_q;
	logic word_q;
	logic neg_lo_q;
	logic neg_hi_q;
	logic special_q;
	// high half is the running sum or remainder, low half the multiplier or quotient.
	logic [2*XLEN-1:0] acc;
	logic [XLEN-1:0] opb;

	logic signed_a;
	logic signed_b;
	logic is_div;
	logic [XLEN-1:0] a_ext;
	logic [XLEN-1:0] b_ext;
	logic neg_a;
	logic neg_b;
	logic [XLEN-1:0] mag_a;
	logic [XLEN-1:0] mag_b;
	logic [XLEN-1:0] min_neg;
	logic div_zero;
	logic div_ovf;
	logic [XLEN:0] mul_sum;
	logic [XLEN:0] div_diff;
	logic [2*XLEN-1:0] acc_fix;
	logic [XLEN-1:0] rem_fix;
	logic [XLEN-1:0] raw;

	// operand signs and magnitudes at issue.
	always_comb begin
		signed_a = (i_md_op == MD_MULH) || (i_md_op == MD_MULHSU) ||
			(i_md_op == MD_DIV) || (i_md_op == MD_REM);
		signed_b = (i_md_op == MD_MULH) || (i_md_op == MD_DIV) || (i_md_op == MD_REM);
		is_div = (i_md_op == MD_DIV) || (i_md_op == MD_DIVU) ||
			(i_md_op == MD_REM) || (i_md_op == MD_REMU);
		a_ext = i_src_a;
		b_ext = i_src_b;
		min_neg = {1'b1, {(XLEN-1){1'b0}}};
		if (i_isword) begin
			a_ext = {{(XLEN-WW){signed_a & i_src_a[WW-1]}}, i_src_a[WW-1:0]};
			b_ext = {{(XLEN-WW){signed_b & i_src_b[WW-1]}}, i_src_b[WW-1:0]};
			min_neg = {{(XLEN-WW+1){1'b1}}, {(WW-1){1'b0}}};
		end
		neg_a = signed_a && a_ext[XLEN-1];
		neg_b = signed_b && b_ext[XLEN-1];
		mag_a = neg_a ? -a_ext : a_ext;
		mag_b = neg_b ? -b_ext : b_ext;
		div_zero = (b_ext == '0);
		div_ovf = signed_b && (a_ext == min_neg) && (b_ext == '1);
	end

	assign mul_sum = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, opb} : '0);
	assign div_diff = acc[2*XLEN-1:XLEN-1] - {1'b0, opb};

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						if (is_div) begin
							state <= ST_DIV;
						end else begin
							state <= ST_MUL;
						end
						cnt <= i_isword ? CNT_W'(WW-1) : CNT_W'(XLEN-1);
					end
				end
				ST_MUL: begin
					cnt <= cnt - 1'b1;
					if (cnt == '0) begin
						state <= ST_DONE;
					end
				end
				ST_DIV: begin
					cnt <= cnt - 1'b1;
					if (special_q || (cnt == '0)) begin
						state <= ST_DONE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		case (state)
			ST_IDLE: begin
				if (i_start) begin
					op_q <= i_md_op;
					word_q <= i_isword;
					special_q <= is_div && (div_zero || div_ovf);
					opb <= is_div ? mag_b : mag_a;
					neg_lo_q <= neg_a ^ neg_b;
					neg_hi_q <= neg_a;
					if (!is_div) begin
						acc <= {{XLEN{1'b0}}, mag_b};
					end else if (div_zero) begin
						// all-ones quotient, dividend as remainder.
						acc <= {a_ext, {XLEN{1'b1}}};
						neg_lo_q <= 1'b0;
						neg_hi_q <= 1'b0;
					end else if (div_ovf) begin
						acc <= {{XLEN{1'b0}}, a_ext};
						neg_lo_q <= 1'b0;
						neg_hi_q <= 1'b0;
					end else begin
						// word dividend moved to the top so 32 steps suffice.
						acc <= {{XLEN{1'b0}}, i_isword ? mag_a << (XLEN-WW) : mag_a};
					end
				end
			end
			ST_MUL: acc <= {mul_sum, acc[XLEN-1:1]};
			ST_DIV: begin
				if (!special_q) begin
					if (!div_diff[XLEN]) begin
						acc <= {div_diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
					end else begin
						acc <= {acc[2*XLEN-2:0], 1'b0};
					end
				end
			end
			default: ;
		endcase
	end

	// sign fix-up and result select.
	always_comb begin
		acc_fix = neg_lo_q ? -acc : acc;
		rem_fix = neg_hi_q ? -acc[2*XLEN-1:XLEN] : acc[2*XLEN-1:XLEN];
		case (op_q)
			MD_MUL:    raw = word_q ? acc_fix[XLEN-1:0] >> (XLEN-WW) : acc_fix[XLEN-1:0];
			MD_MULH,
			MD_MULHSU,
			MD_MULHU:  raw = acc_fix[2*XLEN-1:XLEN];
			MD_DIV,
			MD_DIVU:   raw = acc_fix[XLEN-1:0];
			default:   raw = rem_fix;
		endcase
		o_result = word_q ? {{(XLEN-WW){raw[WW-1]}}, raw[WW-1:0]} : raw;
	end

	assign o_busy = (state == ST_MUL) || (state == ST_DIV);
	assign o_done = (state == ST_DONE);

	// the issuer only starts an idle unit.
	a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_start |-> (state == ST_IDLE));

	a_done_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_done |=> (state == ST_IDLE));

endmodule

`default_nettype wire

// ==== riscv_ex_params.svh ====
`ifndef RISCV_EX_PARAMS_SVH
`define RISCV_EX_PARAMS_SVH

// datapath width of the core.
`define XLEN 64

// destination register tag.
`define REG_ADDR_W 5

// width of the W-suffixed operations.
`define WORD_W 32

`endif

// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

	// alu operations as the decoder drives them.
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b0001,
		ALU_SLL  = 4'b0010,
		ALU_SLT  = 4'b0011,
		ALU_SLTU = 4'b0100,
		ALU_XOR  = 4'b0101,
		ALU_SRL  = 4'b0110,
		ALU_SRA  = 4'b0111,
		ALU_OR   = 4'b1000,
		ALU_AND  = 4'b1001
	} alu_op_e;

	// m-extension operations, encoded as funct3.
	typedef enum logic [2:0] {
		MD_MUL    = 3'b000,
		MD_MULH   = 3'b001,
		MD_MULHSU = 3'b010,
		MD_MULHU  = 3'b011,
		MD_DIV    = 3'b100,
		MD_DIVU   = 3'b101,
		MD_REM    = 3'b110,
		MD_REMU   = 3'b111
	} md_op_e;

endpackage

`default_nettype wire

// ==== riscv_md_pkg.sv ====
`default_nettype none

package riscv_md_pkg;

	// mul/div sequencer.
	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_MUL  = 2'b01,
		ST_DIV  = 2'b10,
		ST_DONE = 2'b11
	} md_state_e;

endpackage

`default_nettype wire

// ==== tb_riscv_core_ex.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "riscv_ex_params.svh"

module tb_riscv_core_ex;
	import riscv_isa_pkg::*;

	localparam int TIMEOUT = 300;

	logic clk;
	logic i_rst_n;
	logic i_valid;
	logic i_md_sel;
	alu_op_e i_alu_op;
	md_op_e i_md_op;
	logic i_isword;
	logic [`XLEN-1:0] i_src_a;
	logic [`XLEN-1:0] i_src_b;
	logic [`REG_ADDR_W-1:0] i_rd;
	logic o_valid;
	logic [`XLEN-1:0] o_result;
	logic [`REG_ADDR_W-1:0] o_rd;
	logic o_busy;

	// expected results, a ring written at issue and read on o_valid.
	logic [`XLEN-1:0] exp_res [0:255];
	logic [`REG_ADDR_W-1:0] exp_rd [0:255];
	logic [7:0] wr_ptr;
	logic [7:0] rd_ptr;
	logic [`REG_ADDR_W-1:0] rd_ctr;
	int errors;
	int tests;
	int failed;
	int err_mark;

	riscv_core_ex_top i_riscv_core_ex_top (
		.i_riscv_core_clk(clk),
		.i_rst_n(i_rst_n),
		.i_valid(i_valid),
		.i_md_sel(i_md_sel),
		.i_alu_op(i_alu_op),
		.i_md_op(i_md_op),
		.i_isword(i_isword),
		.i_src_a(i_src_a),
		.i_src_b(i_src_b),
		.i_rd(i_rd),
		.o_valid(o_valid),
		.o_result(o_result),
		.o_rd(o_rd),
		.o_busy(o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (o_valid) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) !i_rst_n |=> (!o_valid && !o_busy))
		else begin
			$display("mismatch at %0t: o_valid or o_busy high during reset", $time);
			errors++;
		end

	a_result: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_valid |-> (o_result == exp_res[rd_ptr] && o_rd == exp_rd[rd_ptr]))
		else begin
			$display("mismatch at %0t: got %h rd %0d, expected %h rd %0d", $time,
				o_result, o_rd, exp_res[rd_ptr], exp_rd[rd_ptr]);
			errors++;
		end

	a_no_spurious: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_valid |-> (rd_ptr != wr_ptr))
		else begin
			$display("mismatch at %0t: o_valid without an issued operation", $time);
			errors++;
		end

	a_alu_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_valid && !i_md_sel && !o_busy) |=> o_valid)
		else begin
			$display("mismatch at %0t: alu result not one cycle after issue", $time);
			errors++;
		end

	a_busy_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_valid && i_md_sel && !o_busy) |=> o_busy)
		else begin
			$display("mismatch at %0t: o_busy did not rise after mul/div issue", $time);
			errors++;
		end

	a_busy_end: assert property (@(posedge clk) disable iff (!i_rst_n)
		$fell(o_busy) |=> o_valid)
		else begin
			$display("mismatch at %0t: no result one cycle after busy fell", $time);
			errors++;
		end

	a_busy_quiet: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_busy |-> !o_valid)
		else begin
			$display("mismatch at %0t: o_valid while busy", $time);
			errors++;
		end

	function automatic logic [63:0] alu_model(alu_op_e op, logic [63:0] a, logic [63:0] b,
		logic w);
		logic [31:0] r32;
		logic [63:0] r;
		r = '0;
		r32 = '0;
		if (w) begin
			case (op)
				ALU_ADD: r32 = a[31:0] + b[31:0];
				ALU_SUB: r32 = a[31:0] - b[31:0];
				ALU_SLL: r32 = a[31:0] << b[4:0];
				ALU_SRL: r32 = a[31:0] >> b[4:0];
				ALU_SRA: r32 = $signed(a[31:0]) >>> b[4:0];
				default: r32 = '0;
			endcase
			r = {{32{r32[31]}}, r32};
		end else begin
			case (op)
				ALU_ADD:  r = a + b;
				ALU_SUB:  r = a - b;
				ALU_SLL:  r = a << b[5:0];
				ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
				ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
				ALU_XOR:  r = a ^ b;
				ALU_SRL:  r = a >> b[5:0];
				ALU_SRA:  r = $signed(a) >>> b[5:0];
				ALU_OR:   r = a | b;
				ALU_AND:  r = a & b;
				default:  r = '0;
			endcase
		end
		return r;
	endfunction

	function automatic logic [63:0] md_model(md_op_e op, logic [63:0] a, logic [63:0] b,
		logic w);
		logic [127:0] p;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [31:0] wa;
		logic signed [31:0] wb;
		logic signed [63:0] sq;
		logic signed [63:0] srem;
		logic signed [31:0] wq;
		logic signed [31:0] wrem;
		logic [31:0] r32;
		logic [63:0] r;
		logic ovf;
		sa = a;
		sb = b;
		wa = a[31:0];
		wb = b[31:0];
		// signed quotients kept apart so the selects below stay unsigned.
		sq = sa / sb;
		srem = sa % sb;
		wq = wa / wb;
		wrem = wa % wb;
		r = '0;
		r32 = '0;
		if (w) begin
			ovf = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
			case (op)
				MD_MUL:  r32 = a[31:0] * b[31:0];
				MD_DIV:  r32 = (wb == 0) ? '1 : (ovf ? a[31:0] : wq);
				MD_DIVU: r32 = (wb == 0) ? '1 : a[31:0] / b[31:0];
				MD_REM:  r32 = (wb == 0) ? a[31:0] : (ovf ? '0 : wrem);
				MD_REMU: r32 = (wb == 0) ? a[31:0] : a[31:0] % b[31:0];
				default: r32 = '0;
			endcase
			r = {{32{r32[31]}}, r32};
		end else begin
			ovf = (a == 64'h8000_0000_0000_0000) && (b == '1);
			case (op)
				MD_MUL:    r = a * b;
				MD_MULH: begin
					p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
					r = p[127:64];
				end
				MD_MULHSU: begin
					p = {{64{a[63]}}, a} * {64'd0, b};
					r = p[127:64];
				end
				MD_MULHU: begin
					p = {64'd0, a} * {64'd0, b};
					r = p[127:64];
				end
				MD_DIV:  r = (b == 0) ? '1 : (ovf ? a : sq);
				MD_DIVU: r = (b == 0) ? '1 : a / b;
				MD_REM:  r = (b == 0) ? a : (ovf ? '0 : srem);
				default: r = (b == 0) ? a : a % b;
			endcase
		end
		return r;
	endfunction

	task automatic issue_op(input logic md, input alu_op_e aop, input md_op_e mop,
		input logic w, input logic [63:0] a, input logic [63:0] b);
		@(posedge clk);
		i_valid <= 1'b1;
		i_md_sel <= md;
		i_alu_op <= aop;
		i_md_op <= mop;
		i_isword <= w;
		i_src_a <= a;
		i_src_b <= b;
		i_rd <= rd_ctr;
		exp_res[wr_ptr] <= md ? md_model(mop, a, b, w) : alu_model(aop, a, b, w);
		exp_rd[wr_ptr] <= rd_ctr;
		wr_ptr <= wr_ptr + 1'b1;
		rd_ctr = rd_ctr + 1'b1;
	endtask

	task automatic go_idle();
		@(posedge clk);
		i_valid <= 1'b0;
	endtask

	task automatic abort_run(input string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// waits until every issued operation has returned.
	task automatic wait_drain();
		int n;
		n = 0;
		@(negedge clk);
		while (rd_ptr != wr_ptr) begin
			n++;
			if (n > TIMEOUT) begin
				abort_run("outstanding results");
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		@(negedge clk);
		while (!o_valid) begin
			n++;
			if (n > TIMEOUT) begin
				abort_run("o_valid");
			end
			@(negedge clk);
		end
	endtask

	task automatic md_run(input md_op_e mop, input logic w, input logic [63:0] a,
		input logic [63:0] b);
		issue_op(1'b1, ALU_ADD, mop, w, a, b);
		go_idle();
		wait_drain();
	endtask

	task automatic begin_test();
		err_mark = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		if (errors != err_mark) begin
			failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	initial begin
		logic [63:0] ext [0:4];
		alu_op_e wops [0:4];
		void'($urandom(53));
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		i_md_sel = 1'b0;
		i_alu_op = ALU_ADD;
		i_md_op = MD_MUL;
		i_isword = 1'b0;
		i_src_a = '0;
		i_src_b = '0;
		i_rd = '0;
		wr_ptr = '0;
		rd_ptr = '0;
		rd_ctr = 5'd1;
		errors = 0;
		tests = 0;
		failed = 0;
		ext[0] = 64'h8000_0000_0000_0000;
		ext[1] = '1;
		ext[2] = 64'h7fff_ffff_ffff_ffff;
		ext[3] = 64'h0000_0000_8000_0000;
		ext[4] = 64'd0;
		wops[0] = ALU_ADD;
		wops[1] = ALU_SUB;
		wops[2] = ALU_SLL;
		wops[3] = ALU_SRL;
		wops[4] = ALU_SRA;

		begin_test();
		repeat (5) @(posedge clk);
		i_rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		end_test("reset");

		begin_test();
		for (int i = 0; i < 40; i++) begin
			issue_op(1'b0, alu_op_e'($urandom_range(9)), MD_MUL, 1'b0,
				{$urandom, $urandom}, {$urandom, $urandom});
		end
		go_idle();
		wait_drain();
		end_test("alu back-to-back");

		begin_test();
		for (int i = 0; i < 30; i++) begin
			issue_op(1'b0, wops[i % 5], MD_MUL, 1'b1,
				{$urandom, 1'b1, 31'($urandom)}, {$urandom, $urandom});
		end
		go_idle();
		wait_drain();
		end_test("alu word");

		begin_test();
		for (int op = 0; op < 4; op++) begin
			md_run(md_op_e'(op), 1'b0, {$urandom, $urandom}, {$urandom, $urandom});
			md_run(md_op_e'(op), 1'b0, ext[op], ext[(op + 1) % 5]);
			md_run(md_op_e'(op), 1'b0, ext[0], ext[0]);
		end
		md_run(MD_MUL, 1'b1, {$urandom, $urandom}, {$urandom, $urandom});
		md_run(MD_MUL, 1'b1, ext[3], ext[1]);
		end_test("multiply");

		begin_test();
		for (int op = 4; op < 8; op++) begin
			for (int w = 0; w < 2; w++) begin
				md_run(md_op_e'(op), w[0], {$urandom, $urandom}, {32'd0, $urandom});
				md_run(md_op_e'(op), w[0], {$urandom, $urandom}, '0);
				md_run(md_op_e'(op), w[0], w ? ext[3] : ext[0], '1);
				md_run(md_op_e'(op), w[0], ext[1], ext[2]);
			end
		end
		end_test("divide");

		begin_test();
		issue_op(1'b1, ALU_ADD, MD_DIVU, 1'b0, {$urandom, $urandom}, 64'd7);
		go_idle();
		wait_valid();
		issue_op(1'b0, ALU_XOR, MD_MUL, 1'b0, {$urandom, $urandom}, {$urandom, $urandom});
		go_idle();
		wait_drain();
		repeat (4) @(posedge clk);
		end_test("alu after mul/div");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
